//--- wg_disassembler.f
+incdir+include
design/wg_pkg.sv
design/axis_pipe.sv
design/wg_classifier.sv
design/wg_reframer.sv
design/wg_disassembler.sv
tb/wg_disassembler_tb.sv

//--- Bender.yml
package:
  name: wg_disassembler

sources:
  - include_dirs:
      - include
    files:
      - design/wg_pkg.sv
      - design/axis_pipe.sv
      - design/wg_classifier.sv
      - design/wg_reframer.sv
      - design/wg_disassembler.sv
      - target: test
        files:
          - tb/wg_disassembler_tb.sv

//--- tb/wg_disassembler_tb.sv
// Random self-checking testbench that drives the WireGuard RX disassembler as the simulation top
`include "wg_defs.svh"

module wg_disassembler_tb;
    import wg_pkg::*;

    localparam int NUM_PACKETS = 300;
    localparam int MAX_BEATS   = 10;
    localparam int WAIT_LIMIT  = 2000;

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    beat_data_t in_data;
    keep_t      in_keep;
    logic       in_last;
    in_user_t   in_user;
    logic       out_valid;
    logic       out_ready;
    beat_data_t out_data;
    keep_t      out_keep;
    logic       out_last;
    out_user_t  out_user;
    logic       is_idle;

    // Expected output beats in arrival order
    beat_data_t exp_data [$];
    keep_t      exp_keep [$];
    logic       exp_last [$];
    out_user_t  exp_user [$];

    // Packet under construction
    beat_data_t pkt_data [MAX_BEATS];
    keep_t      pkt_keep [MAX_BEATS];
    in_user_t   pkt_user [MAX_BEATS];
    int         pkt_len;

    // Stream 0 feeds packets, stream 1 the output back-pressure
    logic [31:0] lfsr_state [2];
    int          error_count;
    int          beats_checked;
    int          pkt_count;
    int          waited;
    logic        timed_out;

    logic       held_stall;
    beat_data_t held_data;
    keep_t      held_keep;
    logic       held_last;
    out_user_t  held_user;
    beat_data_t e_data;
    keep_t      e_keep;
    logic       e_last;
    out_user_t  e_user;

    wg_disassembler uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .in_user   (in_user),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_last  (out_last),
        .out_user  (out_user),
        .is_idle   (is_idle)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Random numbers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Galois form of x^32 + x^22 + x^2 + x + 1
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int stream, input int n);
        logic [31:0] s;
        logic [31:0] v;
        s = lfsr_state[stream];
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], s[0]};
            s = lfsr_next(s);
        end
        lfsr_state[stream] = s;
        return v;
    endfunction

    function automatic beat_data_t rand_beat();
        beat_data_t b;
        for (int w = 0; w < 4; w++) begin
            b[w*32 +: 32] = rand_bits(0, 32);
        end
        return b;
    endfunction

    // Never zero, so a corrupted field always differs
    function automatic logic [15:0] flip_mask(input int n);
        return 16'(rand_bits(0, n)) | 16'h0001;
    endfunction

    // ------------------------------------------------------------------------
    // Checking and end of run
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Run finished: %0d packets sent, %0d beats checked, %0d errors",
                 pkt_count, beats_checked, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // ------------------------------------------------------------------------
    // Packet generator and reference model
    // ------------------------------------------------------------------------
    task automatic build_packet();
        logic want_wg;
        logic port_hi;
        int   field;
        pkt_len = 1 + int'(rand_bits(0, 8) % MAX_BEATS);
        want_wg = (rand_bits(0, 1) != 0);
        port_hi = (rand_bits(0, 1) != 0);
        for (int i = 0; i < MAX_BEATS; i++) begin
            pkt_data[i] = rand_beat();
            pkt_keep[i] = keep_t'(rand_bits(0, 16));
            pkt_user[i] = in_user_t'(rand_bits(0, 5));
        end
        // Well formed outer headers and WireGuard type
        pkt_data[0][111:96]  = `WG_ETHERTYPE_IP;
        pkt_data[0][119:116] = `WG_IP_VERSION;
        pkt_data[1][63:56]   = `WG_PROTO_UDP;
        if (port_hi) begin
            pkt_data[2][47:32] = `WG_UDP_PORT;
        end else begin
            pkt_data[2][31:16] = `WG_UDP_PORT;
        end
        pkt_data[2][87:80] = `WG_MSG_DATA;
        if (!want_wg) begin
            field = int'(rand_bits(0, 8) % 5);
            case (field)
                0: pkt_data[0][111:96] = pkt_data[0][111:96] ^ flip_mask(16);
                1: pkt_data[0][119:116] = pkt_data[0][119:116] ^ 4'(flip_mask(4));
                2: pkt_data[1][63:56] = pkt_data[1][63:56] ^ 8'(flip_mask(8));
                3: begin
                    if (port_hi) begin
                        pkt_data[2][47:32] = pkt_data[2][47:32] ^ flip_mask(16);
                    end else begin
                        pkt_data[2][31:16] = pkt_data[2][31:16] ^ flip_mask(16);
                    end
                end
                default: pkt_data[2][87:80] = pkt_data[2][87:80] ^ 8'(flip_mask(8));
            endcase
        end
    endtask

    task automatic model_packet();
        logic        is_wg;
        logic [31:0] rcv;
        logic [63:0] cnt;
        out_user_t   user;
        is_wg = (pkt_len >= 3) &&
                (pkt_data[0][111:96] == 16'h0008) && (pkt_data[0][119:116] == 4'h4) &&
                (pkt_data[1][63:56] == 8'h11) && (pkt_data[2][87:80] == 8'h04) &&
                ((pkt_data[2][47:32] == 16'h6cca) || (pkt_data[2][31:16] == 16'h6cca));
        if (!is_wg) begin
            for (int i = 0; i < pkt_len; i++) begin
                exp_data.push_back(pkt_data[i]);
                exp_keep.push_back(pkt_keep[i]);
                exp_last.push_back(i == pkt_len - 1);
                exp_user.push_back(out_user_t'(pkt_user[i]));
            end
        end else begin
            rcv = {pkt_data[3][15:0], pkt_data[2][127:112]};
            cnt = pkt_data[3][79:16];
            // Beats 0..4 only feed headers and the first carry
            for (int k = 5; k < pkt_len; k++) begin
                user          = '0;
                user[127:96]  = rcv;
                user[95:32]   = cnt;
                user[5]       = 1'b1;
                user[4:0]     = pkt_user[k];
                exp_data.push_back({pkt_data[k][79:0], pkt_data[k-1][127:80]});
                exp_keep.push_back('1);
                exp_last.push_back(k == pkt_len - 1);
                exp_user.push_back(user);
            end
        end
    endtask

    task automatic send_beat(input int i);
        int gap;
        int tries;
        gap = (rand_bits(0, 2) == 0) ? int'(rand_bits(0, 2)) : 0;
        repeat (gap) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        in_valid <= 1'b1;
        in_data  <= pkt_data[i];
        in_keep  <= pkt_keep[i];
        in_last  <= (i == pkt_len - 1);
        in_user  <= pkt_user[i];
        tries = 0;
        do begin
            @(posedge clk);
            tries++;
            if (tries > WAIT_LIMIT) begin
                error_count++;
                timed_out = 1'b1;
                $display("Timeout: input beat %0d of packet %0d was never accepted",
                         i, pkt_count);
            end
        end while (!in_ready && !timed_out);
    endtask

    // ------------------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        out_ready <= (rand_bits(1, 2) != 2'd0);
    end

    always @(posedge clk) begin
        if (rst) begin
            held_stall <= 1'b0;
        end else begin
            // A stalled beat must not move
            if (held_stall) begin
                check_value("out_valid while stalled", 1, out_valid);
                check_value("out_data while stalled", held_data, out_data);
                check_value("out_keep while stalled", held_keep, out_keep);
                check_value("out_last while stalled", held_last, out_last);
                check_value("out_user while stalled", held_user, out_user);
            end
            if (out_valid && out_ready) begin
                if (exp_data.size() == 0) begin
                    error_count++;
                    $display("Output beat at time %0t arrived while none was expected", $time);
                end else begin
                    e_data = exp_data.pop_front();
                    e_keep = exp_keep.pop_front();
                    e_last = exp_last.pop_front();
                    e_user = exp_user.pop_front();
                    check_value("out_data", e_data, out_data);
                    check_value("out_keep", e_keep, out_keep);
                    check_value("out_last", e_last, out_last);
                    check_value("out_user", e_user, out_user);
                    beats_checked++;
                end
            end
            held_stall <= out_valid && !out_ready;
            held_data  <= out_data;
            held_keep  <= out_keep;
            held_last  <= out_last;
            held_user  <= out_user;
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_data       = '0;
        in_keep       = '0;
        in_last       = 1'b0;
        in_user       = '0;
        out_ready     = 1'b0;
        lfsr_state[0] = 32'hee9b;
        lfsr_state[1] = lfsr_next(32'hee9b) ^ 32'h5a5a_0000;
        error_count   = 0;
        beats_checked = 0;
        pkt_count     = 0;
        timed_out     = 1'b0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("out_valid after reset", 0, out_valid);
        check_value("is_idle after reset", 1, is_idle);

        for (int p = 0; p < NUM_PACKETS && !timed_out; p++) begin
            build_packet();
            model_packet();
            for (int i = 0; i < pkt_len && !timed_out; i++) begin
                send_beat(i);
            end
            if (!timed_out) begin
                pkt_count++;
            end
        end
        in_valid <= 1'b0;
        in_last  <= 1'b0;

        waited = 0;
        while (!timed_out && exp_data.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                error_count++;
                timed_out = 1'b1;
                $display("Timeout: %0d expected beats never came out", exp_data.size());
            end
        end

        waited = 0;
        while (!timed_out && !is_idle) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                error_count++;
                timed_out = 1'b1;
                $display("Timeout: the DUT did not return to idle after the traffic ended");
            end
        end
        finish_run();
    end

endmodule

//--- design/wg_disassembler.sv
// Top level of the WireGuard RX disassembler, instantiated by the data-plane receive path
`include "wg_defs.svh"

module wg_disassembler (
    input  logic               clk,
    input  logic               rst,

    input  logic               in_valid,
    output logic               in_ready,
    input  wg_pkg::beat_data_t in_data,
    input  wg_pkg::keep_t      in_keep,
    input  logic               in_last,
    input  wg_pkg::in_user_t   in_user,

    output logic               out_valid,
    input  logic               out_ready,
    output wg_pkg::beat_data_t out_data,
    output wg_pkg::keep_t      out_keep,
    output logic               out_last,
    output wg_pkg::out_user_t  out_user,

    output logic               is_idle
);
    import wg_pkg::*;

    // Lookahead pipeline to reframer
    logic       mid_valid;
    logic       mid_ready;
    beat_data_t mid_data;
    keep_t      mid_keep;
    logic       mid_last;
    in_user_t   mid_user;

    // Reframer to output skid
    logic       pre_valid;
    logic       pre_ready;
    beat_data_t pre_data;
    keep_t      pre_keep;
    logic       pre_last;
    out_user_t  pre_user;

    logic       verdict_valid;
    verdict_t   verdict_wg;
    logic       verdict_pop;
    logic       cls_idle;

    axis_pipe #(
        .data_t (beat_data_t),
        .user_t (in_user_t),
        .DEPTH  (`WG_PIPE_DEPTH)
    ) input_pipe (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .in_user   (in_user),
        .out_valid (mid_valid),
        .out_data  (mid_data),
        .out_keep  (mid_keep),
        .out_last  (mid_last),
        .out_user  (mid_user),
        .out_ready (mid_ready)
    );

    wg_classifier classifier (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_data       (in_data),
        .in_last       (in_last),
        .verdict_valid (verdict_valid),
        .verdict_wg    (verdict_wg),
        .verdict_pop   (verdict_pop),
        .cls_idle      (cls_idle)
    );

    wg_reframer reframer (
        .clk           (clk),
        .rst           (rst),
        .mid_valid     (mid_valid),
        .mid_ready     (mid_ready),
        .mid_data      (mid_data),
        .mid_keep      (mid_keep),
        .mid_last      (mid_last),
        .mid_user      (mid_user),
        .verdict_valid (verdict_valid),
        .verdict_wg    (verdict_wg),
        .cls_idle      (cls_idle),
        .verdict_pop   (verdict_pop),
        .pre_valid     (pre_valid),
        .pre_data      (pre_data),
        .pre_keep      (pre_keep),
        .pre_last      (pre_last),
        .pre_user      (pre_user),
        .pre_ready     (pre_ready),
        .out_valid     (out_valid),
        .is_idle       (is_idle)
    );

    // Single stage cuts the ready path from the output port
    axis_pipe #(
        .data_t (beat_data_t),
        .user_t (out_user_t),
        .DEPTH  (1)
    ) out_skid (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (pre_valid),
        .in_ready  (pre_ready),
        .in_data   (pre_data),
        .in_keep   (pre_keep),
        .in_last   (pre_last),
        .in_user   (pre_user),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_last  (out_last),
        .out_user  (out_user),
        .out_ready (out_ready)
    );

endmodule

//--- design/wg_reframer.sv
// Output-side FSMD that forwards bypass packets and strips and realigns WireGuard payload
`include "wg_defs.svh"

module wg_reframer (
    input  logic               clk,
    input  logic               rst,

    input  logic               mid_valid,
    output logic               mid_ready,
    input  wg_pkg::beat_data_t mid_data,
    input  wg_pkg::keep_t      mid_keep,
    input  logic               mid_last,
    input  wg_pkg::in_user_t   mid_user,

    input  logic               verdict_valid,
    input  wg_pkg::verdict_t   verdict_wg,
    input  logic               cls_idle,
    output logic               verdict_pop,

    output logic               pre_valid,
    output wg_pkg::beat_data_t pre_data,
    output wg_pkg::keep_t      pre_keep,
    output logic               pre_last,
    output wg_pkg::out_user_t  pre_user,
    input  logic               pre_ready,

    input  logic               out_valid,
    output logic               is_idle
);
    import wg_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_BYPASS,
        S_HDR1,
        S_HDR2,
        S_HDR3,
        S_CARRY,
        S_DATA
    } state_t;

    state_t      state;
    state_t      next_state;
    logic        mid_xfer;
    logic [31:0] wg_rcv;
    logic [63:0] wg_cnt;
    logic [47:0] carry;

    assign mid_xfer = mid_valid && mid_ready;

    // ------------------------------------------------------------------------
    // Handshake and datapath select
    // ------------------------------------------------------------------------
    always_comb begin
        mid_ready   = 1'b0;
        verdict_pop = 1'b0;
        pre_valid   = 1'b0;
        pre_data    = mid_data;
        pre_keep    = mid_keep;
        pre_last    = mid_last;
        pre_user    = '0;
        pre_user[`WG_IN_USER_W-1:0] = mid_user;

        case (state)
            S_IDLE: begin
                // First beat waits for its verdict
                if (verdict_valid) begin
                    if (verdict_wg == VERDICT_WG) begin
                        mid_ready = 1'b1;
                    end else begin
                        mid_ready = pre_ready;
                        pre_valid = mid_valid;
                    end
                    verdict_pop = mid_valid && mid_ready;
                end
            end
            S_BYPASS: begin
                mid_ready = pre_ready;
                pre_valid = mid_valid;
            end
            S_HDR1, S_HDR2, S_HDR3, S_CARRY: begin
                // Header beats are swallowed
                mid_ready = 1'b1;
            end
            S_DATA: begin
                mid_ready = pre_ready;
                pre_valid = mid_valid;
                pre_data  = {mid_data[79:0], carry};
                pre_keep  = '1;
                pre_user[RCV_HI:RCV_LO] = wg_rcv;
                pre_user[CNT_HI:CNT_LO] = wg_cnt;
                pre_user[DECAP_B]       = 1'b1;
            end
            default: mid_ready = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Packet position
    // ------------------------------------------------------------------------
    always_comb begin
        next_state = state;
        if (mid_xfer) begin
            if (mid_last) begin
                next_state = S_IDLE;
            end else begin
                case (state)
                    S_IDLE:   next_state = (verdict_wg == VERDICT_WG) ? S_HDR1 : S_BYPASS;
                    S_BYPASS: next_state = S_BYPASS;
                    S_HDR1:   next_state = S_HDR2;
                    S_HDR2:   next_state = S_HDR3;
                    S_HDR3:   next_state = S_CARRY;
                    S_CARRY:  next_state = S_DATA;
                    default:  next_state = S_DATA;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Receiver index straddles beats 2 and 3
    always_ff @(posedge clk) begin
        if (mid_xfer) begin
            case (state)
                S_HDR2: wg_rcv[15:0] <= mid_data[127:112];
                S_HDR3: begin
                    wg_rcv[31:16] <= mid_data[15:0];
                    wg_cnt        <= mid_data[79:16];
                end
                S_CARRY, S_DATA: carry <= mid_data[127:80];
                default: carry <= carry;
            endcase
        end
    end

    assign is_idle = cls_idle && !verdict_valid && !mid_valid &&
                     (state == S_IDLE) && !out_valid;

endmodule

//--- design/wg_classifier.sv
// Input-side header matcher, queues one WireGuard/bypass verdict per packet for the reframer
`include "wg_defs.svh"

module wg_classifier (
    input  logic               clk,
    input  logic               rst,

    // Monitored input handshake
    input  logic               in_valid,
    input  logic               in_ready,
    input  wg_pkg::beat_data_t in_data,
    input  logic               in_last,

    output logic               verdict_valid,
    output wg_pkg::verdict_t   verdict_wg,
    input  logic               verdict_pop,

    output logic               cls_idle
);
    import wg_pkg::*;

    localparam int QD    = `WG_VERDICT_DEPTH;
    localparam int PTR_W = (QD > 1) ? $clog2(QD) : 1;
    localparam int CNT_W = $clog2(QD + 1);

    typedef enum logic [1:0] {
        POS_BEAT0,
        POS_BEAT1,
        POS_BEAT2,
        POS_SKIP
    } pos_t;

    pos_t             pos;
    logic             hdr_ok;
    logic             xfer;
    logic             hdr0_match;
    logic             hdr1_match;
    logic             hdr2_match;
    logic             push;
    verdict_t         push_verdict;

    verdict_t         queue [QD];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign xfer = in_valid && in_ready;

    // Ethernet type and IPv4 version
    assign hdr0_match = (in_data[111:96] == `WG_ETHERTYPE_IP) &&
                        (in_data[119:116] == `WG_IP_VERSION);
    assign hdr1_match = (in_data[63:56] == `WG_PROTO_UDP);
    // Port may sit on either side of the UDP header
    assign hdr2_match = ((in_data[47:32] == `WG_UDP_PORT) ||
                         (in_data[31:16] == `WG_UDP_PORT)) &&
                        (in_data[87:80] == `WG_MSG_DATA);

    // ------------------------------------------------------------------------
    // Beat position and match accumulation
    // ------------------------------------------------------------------------
    always_comb begin
        push         = 1'b0;
        push_verdict = VERDICT_BYPASS;
        if (xfer) begin
            case (pos)
                POS_BEAT0, POS_BEAT1: push = in_last;
                POS_BEAT2: begin
                    push = 1'b1;
                    if (hdr_ok && hdr2_match) begin
                        push_verdict = VERDICT_WG;
                    end
                end
                default: push = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pos    <= POS_BEAT0;
            hdr_ok <= 1'b0;
        end else if (xfer) begin
            case (pos)
                POS_BEAT0: begin
                    hdr_ok <= hdr0_match;
                    pos    <= in_last ? POS_BEAT0 : POS_BEAT1;
                end
                POS_BEAT1: begin
                    hdr_ok <= hdr_ok && hdr1_match;
                    pos    <= in_last ? POS_BEAT0 : POS_BEAT2;
                end
                POS_BEAT2: pos <= in_last ? POS_BEAT0 : POS_SKIP;
                default:   pos <= in_last ? POS_BEAT0 : POS_SKIP;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Verdict queue
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= push_verdict;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QD - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (verdict_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QD - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, verdict_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign verdict_valid = (count != '0);
    assign verdict_wg    = queue[rd_ptr];
    // No packet half-way through the header
    assign cls_idle      = (pos == POS_BEAT0);

endmodule

//--- design/axis_pipe.sv
// Chain of skid register stages with registered ready, used for header lookahead and output decoupling
module axis_pipe #(
    parameter type data_t = wg_pkg::beat_data_t,
    parameter type user_t = wg_pkg::in_user_t,
    parameter int  DEPTH  = 1
) (
    input  logic           clk,
    input  logic           rst,

    input  logic           in_valid,
    output logic           in_ready,
    input  data_t          in_data,
    input  wg_pkg::keep_t  in_keep,
    input  logic           in_last,
    input  user_t          in_user,

    output logic           out_valid,
    output data_t          out_data,
    output wg_pkg::keep_t  out_keep,
    output logic           out_last,
    output user_t          out_user,
    input  logic           out_ready
);
    import wg_pkg::*;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        user_t user;
    } beat_t;

    // Link k feeds stage k, link DEPTH is the output
    logic  link_valid [DEPTH+1];
    logic  link_ready [DEPTH+1];
    beat_t link_beat  [DEPTH+1];

    assign link_valid[0] = in_valid;
    assign link_beat[0]  = {in_data, in_keep, in_last, in_user};
    assign in_ready      = link_ready[0];

    // ------------------------------------------------------------------------
    // Stages
    // ------------------------------------------------------------------------
    for (genvar s = 0; s < DEPTH; s++) begin : g_stage
        logic  main_valid;
        logic  skid_valid;
        beat_t main_beat;
        beat_t skid_beat;
        logic  up_xfer;
        logic  dn_xfer;

        // Ready only depends on the skid slot, so it comes straight from a flop
        assign link_ready[s] = !skid_valid;
        assign up_xfer       = link_valid[s] && !skid_valid;
        assign dn_xfer       = main_valid && link_ready[s+1];

        always_ff @(posedge clk) begin
            if (rst) begin
                main_valid <= 1'b0;
                skid_valid <= 1'b0;
            end else if (dn_xfer) begin
                if (skid_valid) begin
                    skid_valid <= 1'b0;
                end else begin
                    main_valid <= up_xfer;
                end
            end else if (up_xfer) begin
                if (main_valid) begin
                    skid_valid <= 1'b1;
                end else begin
                    main_valid <= 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (dn_xfer && skid_valid) begin
                main_beat <= skid_beat;
            end else if (up_xfer && (!main_valid || dn_xfer)) begin
                main_beat <= link_beat[s];
            end
            // Park the beat when main is full and stalled
            if (up_xfer && main_valid && !dn_xfer) begin
                skid_beat <= link_beat[s];
            end
        end

        assign link_valid[s+1] = main_valid;
        assign link_beat[s+1]  = main_beat;
    end

    assign link_ready[DEPTH] = out_ready;
    assign out_valid         = link_valid[DEPTH];
    assign out_data          = link_beat[DEPTH].data;
    assign out_keep          = link_beat[DEPTH].keep;
    assign out_last          = link_beat[DEPTH].last;
    assign out_user          = link_beat[DEPTH].user;

endmodule

//--- design/wg_pkg.sv
// Shared beat, sideband and verdict types for the WireGuard RX disassembler and its testbench
`include "wg_defs.svh"

package wg_pkg;

    // One stream beat
    typedef logic [`WG_DATA_W-1:0] beat_data_t;

    // Byte enables, one per data byte
    typedef logic [`WG_KEEP_W-1:0] keep_t;

    // Sideband entering the disassembler
    typedef logic [`WG_IN_USER_W-1:0] in_user_t;

    // Sideband leaving the disassembler
    //   127..96  receiver index
    //    95..32  counter
    //         5  decapsulated flag
    //      4..0  input sideband copied through
    typedef logic [`WG_OUT_USER_W-1:0] out_user_t;

    // Per packet decision of the classifier
    typedef enum logic {
        VERDICT_BYPASS = 1'b0,
        VERDICT_WG     = 1'b1
    } verdict_t;

    // Fields of the output sideband
    localparam int RCV_HI  = 127;
    localparam int RCV_LO  = 96;
    localparam int CNT_HI  = 95;
    localparam int CNT_LO  = 32;
    localparam int DECAP_B = 5;

endpackage

//--- include/wg_defs.svh
// Stream widths, pipeline depths and header match constants, included by the WireGuard RX sources
`ifndef WG_DEFS_SVH
`define WG_DEFS_SVH

// ------------------------------------------------------------------------
// Stream geometry
// ------------------------------------------------------------------------
`define WG_DATA_W        128
`define WG_KEEP_W        16
`define WG_IN_USER_W     5
`define WG_OUT_USER_W    128

// Lookahead stages in front of the reframer
`define WG_PIPE_DEPTH    3
`define WG_VERDICT_DEPTH 4

// ------------------------------------------------------------------------
// Header match values, already in wire byte order
// ------------------------------------------------------------------------
`define WG_ETHERTYPE_IP  16'h0008
`define WG_IP_VERSION    4'h4
`define WG_PROTO_UDP     8'h11
`define WG_UDP_PORT      16'h6cca
`define WG_MSG_DATA      8'h04

`endif
